//--- design/mcu_cmd_pkg.sv
package mcu_cmd_pkg;

  // address and field widths
  localparam int ROM_ADDR_W   = 24;
  localparam int DAC_ADDR_W   = 11;
  localparam int MSU_ADDR_W   = 14;
  localparam int DAC_PTR_W    = 9;
  localparam int MSU_STATUS_W = 6;

  // spi byte index, opcode is byte 1
  typedef logic [7:0] byte_cnt_t;

  // opcode byte seen as group/sub pair or as a full byte
  typedef union packed {
    struct packed {
      logic [3:0] group;
      logic [3:0] sub;
    } fields;
    logic [7:0] raw;
  } cmd_byte_u;

  //////////////////////////////////////////////////
  // command groups (high nibble)
  localparam logic [3:0] GRP_ADDR_LOAD = 4'h0;
  localparam logic [3:0] GRP_ROM_MASK  = 4'h1;
  localparam logic [3:0] GRP_SRAM      = 4'h2;
  localparam logic [3:0] GRP_MAPPER    = 4'h3;
  localparam logic [3:0] GRP_MEM_READ  = 4'h8;
  localparam logic [3:0] GRP_MEM_WRITE = 4'h9;

  //////////////////////////////////////////////////
  // full-byte opcodes
  localparam logic [7:0] OP_MSU_STATUS = 8'hE0;
  localparam logic [7:0] OP_DAC_PAUSE  = 8'hE1;
  localparam logic [7:0] OP_DAC_PLAY   = 8'hE2;
  localparam logic [7:0] OP_DAC_PTR    = 8'hE3;
  localparam logic [7:0] OP_MSU_PTR    = 8'hE4;
  localparam logic [7:0] OP_DAC_PROPS  = 8'hEC;
  localparam logic [7:0] OP_SIGNATURE  = 8'hF0;
  localparam logic [7:0] OP_STATUS     = 8'hF1;
  localparam logic [7:0] OP_ECHO       = 8'hFF;

endpackage

//--- design/cart_config_regs.sv
`timescale 1ns/1ps

module cart_config_regs import mcu_cmd_pkg::*; #(
  parameter logic [2:0] MAPPER_DEFAULT = 3'd1
) (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  cmd_ready,
  input  logic                  param_ready,
  input  cmd_byte_u             cmd_data,
  input  logic [7:0]            param_data,
  input  byte_cnt_t             spi_byte_cnt,
  output logic [2:0]            mapper,
  output logic [ROM_ADDR_W-1:0] rom_mask,
  output logic [ROM_ADDR_W-1:0] saveram_mask,
  output logic [7:0]            saveram_base
);

  always_ff @(posedge clk) begin
    if (reset) begin
      mapper       <= MAPPER_DEFAULT;
      rom_mask     <= '0;
      saveram_mask <= '0;
      saveram_base <= '0;
    end else if (cmd_ready) begin
      if (cmd_data.fields.group == GRP_MAPPER)
        mapper <= cmd_data.fields.sub[2:0];
    end else if (param_ready) begin
      case (cmd_data.fields.group)
        GRP_ROM_MASK: begin
          case (spi_byte_cnt)
            8'd2: rom_mask[23:16] <= param_data; // high byte first
            8'd3: rom_mask[15:8]  <= param_data;
            8'd4: rom_mask[7:0]   <= param_data;
            default: ;
          endcase
        end
        GRP_SRAM: begin
          case (spi_byte_cnt)
            8'd2: begin
              // odd opcode carries the base instead
              if (cmd_data.fields.sub[0])
                saveram_base <= param_data;
              else
                saveram_mask[23:16] <= param_data;
            end
            8'd3: saveram_mask[15:8] <= param_data;
            8'd4: saveram_mask[7:0]  <= param_data;
            default: ;
          endcase
        end
        default: ;
      endcase
    end
  end

endmodule

//--- design/mem_addr_pointers.sv
`timescale 1ns/1ps

module mem_addr_pointers import mcu_cmd_pkg::*; (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  param_ready,
  input  cmd_byte_u             cmd_data,
  input  logic [7:0]            param_data,
  input  byte_cnt_t             spi_byte_cnt,
  input  logic                  mem_next,
  output logic [ROM_ADDR_W-1:0] addr_out,
  output logic [DAC_ADDR_W-1:0] dac_addr_out,
  output logic [MSU_ADDR_W-1:0] msu_addr_out
);

  logic ptr_load;
  logic rom_inc;

  assign ptr_load = param_ready && (cmd_data.fields.group == GRP_ADDR_LOAD);

  // opcode bit 4 delays the first increment by one byte
  assign rom_inc = mem_next
                && (cmd_data.fields.group == GRP_MEM_READ
                    || cmd_data.fields.group == GRP_MEM_WRITE)
                && cmd_data.fields.sub[3]
                && (spi_byte_cnt >= {7'd0, cmd_data.fields.group[0]} + 8'd1);

  always_ff @(posedge clk) begin
    if (reset) begin
      addr_out     <= '0;
      dac_addr_out <= '0;
      msu_addr_out <= '0;
    end else if (ptr_load) begin
      case (cmd_data.fields.sub[1:0])
        2'b01: begin
          if (spi_byte_cnt == 8'd2)
            dac_addr_out <= {param_data[DAC_ADDR_W-9:0], 8'h00};
          else if (spi_byte_cnt == 8'd3)
            dac_addr_out[7:0] <= param_data;
        end
        2'b10: begin
          if (spi_byte_cnt == 8'd2)
            msu_addr_out <= {param_data[MSU_ADDR_W-9:0], 8'h00};
          else if (spi_byte_cnt == 8'd3)
            msu_addr_out[7:0] <= param_data;
        end
        default: begin
          case (spi_byte_cnt)
            8'd2: addr_out <= {param_data, 16'h0000}; // clears the rest
            8'd3: addr_out[15:8] <= param_data;
            8'd4: addr_out[7:0]  <= param_data;
            default: ;
          endcase
        end
      endcase
    end else if (rom_inc) begin
      addr_out <= addr_out + 1'b1;
    end
  end

endmodule

//--- design/mcu_mem_access.sv
`timescale 1ns/1ps

module mcu_mem_access import mcu_cmd_pkg::*; (
  input  logic       clk,
  input  logic       reset,
  input  logic       cmd_ready,
  input  logic       param_ready,
  input  cmd_byte_u  cmd_data,
  input  logic [7:0] param_data,
  input  logic       mcu_rq_rdy,
  output logic       mcu_rrq,
  output logic       mcu_wrq,
  output logic [7:0] mcu_data_out,
  output logic       mem_next
);

  logic [2:0] rdy_hist; // bit 0 is the newest sample

  //////////////////////////////////////////////////
  // request pulses
  always_ff @(posedge clk) begin
    if (reset) begin
      mcu_rrq <= 1'b0;
      mcu_wrq <= 1'b0;
    end else begin
      mcu_rrq <= (cmd_ready || param_ready) && (cmd_data.fields.group == GRP_MEM_READ);
      mcu_wrq <= param_ready && (cmd_data.fields.group == GRP_MEM_WRITE);
    end
  end

  always_ff @(posedge clk) begin
    if (param_ready && cmd_data.fields.group == GRP_MEM_WRITE)
      mcu_data_out <= param_data; // held until next write byte
  end

  //////////////////////////////////////////////////
  // rq_rdy rising edge
  always_ff @(posedge clk) begin
    if (reset)
      rdy_hist <= '0;
    else
      rdy_hist <= {rdy_hist[1:0], mcu_rq_rdy};
  end

  assign mem_next = (rdy_hist == 3'b001);

endmodule

//--- design/spi_readback.sv
`timescale 1ns/1ps

module spi_readback import mcu_cmd_pkg::*; #(
  parameter logic [7:0] SIGNATURE = 8'hA5
) (
  input  logic       clk,
  input  logic       reset,
  input  logic       cmd_ready,
  input  logic       param_ready,
  input  cmd_byte_u  cmd_data,
  input  logic [7:0] param_data,
  input  byte_cnt_t  spi_byte_cnt,
  input  logic       mem_next,
  input  logic [7:0] mcu_data_in,
  input  logic       dac_status,
  input  logic [7:0] msu_status,
  output logic [7:0] spi_data_out
);

  logic       dac_status_r;
  logic [7:0] msu_status_r;

  // status inputs come from other clock logic
  always_ff @(posedge clk) begin
    dac_status_r <= dac_status;
    msu_status_r <= msu_status;
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      spi_data_out <= '0;
    end else if (mem_next && cmd_data.fields.group == GRP_MEM_READ) begin
      spi_data_out <= mcu_data_in; // memory read data
    end else if (cmd_ready || param_ready) begin
      case (cmd_data.raw)
        OP_SIGNATURE: spi_data_out <= SIGNATURE;
        OP_ECHO:      spi_data_out <= param_data;
        OP_STATUS: begin
          if (spi_byte_cnt[0])
            spi_data_out <= {1'b0, dac_status_r, msu_status_r[7], 5'b00000};
          else
            spi_data_out <= {1'b0, msu_status_r[6:0]};
        end
        default: ;
      endcase
    end
  end

endmodule

//--- design/audio_stream_ctrl.sv
`timescale 1ns/1ps

module audio_stream_ctrl import mcu_cmd_pkg::*; (
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    param_ready,
  input  cmd_byte_u               cmd_data,
  input  logic [7:0]              param_data,
  input  byte_cnt_t               spi_byte_cnt,
  output logic                    dac_play,
  output logic                    dac_reset,
  output logic [2:0]              dac_vol,
  output logic                    dac_palmode,
  output logic [DAC_PTR_W-1:0]    dac_ptr,
  output logic [MSU_ADDR_W-1:0]   msu_ptr,
  output logic                    msu_reset,
  output logic [MSU_STATUS_W-1:0] msu_status_set,
  output logic [MSU_STATUS_W-1:0] msu_status_clr,
  output logic                    msu_status_we
);

  always_ff @(posedge clk) begin
    if (reset) begin
      dac_play      <= 1'b0;
      dac_reset     <= 1'b0;
      dac_vol       <= '0;
      dac_palmode   <= 1'b0;
      dac_ptr       <= '0;
      msu_ptr       <= '0;
      msu_reset     <= 1'b0;
      msu_status_we <= 1'b0;
    end else begin
      dac_reset <= 1'b0; // pulses
      msu_reset <= 1'b0;
      if (param_ready) begin
        case (cmd_data.raw)
          OP_DAC_PAUSE: dac_play <= 1'b0;
          OP_DAC_PLAY:  dac_play <= 1'b1;
          OP_DAC_PTR: begin
            if (spi_byte_cnt == 8'd2) begin
              dac_ptr[8] <= param_data[0];
            end else if (spi_byte_cnt == 8'd3) begin
              dac_ptr[7:0] <= param_data;
              dac_reset    <= 1'b1; // restart playback at dac_ptr
            end
          end
          OP_DAC_PROPS: begin
            dac_vol     <= param_data[2:0];
            dac_palmode <= param_data[7];
          end
          OP_MSU_PTR: begin
            if (spi_byte_cnt == 8'd2) begin
              msu_ptr <= {param_data[MSU_ADDR_W-9:0], 8'h00};
            end else if (spi_byte_cnt == 8'd3) begin
              msu_ptr[7:0] <= param_data;
              msu_reset    <= 1'b1;
            end
          end
          OP_MSU_STATUS: begin
            case (spi_byte_cnt)
              8'd2: msu_status_set <= param_data[MSU_STATUS_W-1:0];
              8'd3: begin
                msu_status_clr <= param_data[MSU_STATUS_W-1:0];
                msu_status_we  <= 1'b1; // held for one byte time
              end
              8'd4: msu_status_we <= 1'b0;
              default: ;
            endcase
          end
          default: ;
        endcase
      end
    end
  end

endmodule

//--- design/mcu_cmd_top.sv
`timescale 1ns/1ps

module mcu_cmd_top import mcu_cmd_pkg::*; #(
  parameter logic [7:0] SIGNATURE      = 8'hA5,
  parameter logic [2:0] MAPPER_DEFAULT = 3'd1
) (
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    cmd_ready,
  input  logic                    param_ready,
  input  cmd_byte_u               cmd_data,
  input  logic [7:0]              param_data,
  input  byte_cnt_t               spi_byte_cnt,
  input  logic                    mcu_rq_rdy,
  input  logic [7:0]              mcu_data_in,
  input  logic                    dac_status,
  input  logic [7:0]              msu_status,
  output logic [2:0]              mapper,
  output logic [ROM_ADDR_W-1:0]   rom_mask,
  output logic [ROM_ADDR_W-1:0]   saveram_mask,
  output logic [7:0]              saveram_base,
  output logic [ROM_ADDR_W-1:0]   addr_out,
  output logic [DAC_ADDR_W-1:0]   dac_addr_out,
  output logic [MSU_ADDR_W-1:0]   msu_addr_out,
  output logic                    mcu_rrq,
  output logic                    mcu_wrq,
  output logic [7:0]              mcu_data_out,
  output logic [7:0]              spi_data_out,
  output logic                    dac_play,
  output logic                    dac_reset,
  output logic [2:0]              dac_vol,
  output logic                    dac_palmode,
  output logic [DAC_PTR_W-1:0]    dac_ptr,
  output logic [MSU_ADDR_W-1:0]   msu_ptr,
  output logic                    msu_reset,
  output logic [MSU_STATUS_W-1:0] msu_status_set,
  output logic [MSU_STATUS_W-1:0] msu_status_clr,
  output logic                    msu_status_we
);

  logic mem_next; // end of one memory request

  cart_config_regs #(.MAPPER_DEFAULT(MAPPER_DEFAULT)) u_cfg (
    .clk, .reset, .cmd_ready, .param_ready,
    .cmd_data, .param_data, .spi_byte_cnt,
    .mapper, .rom_mask, .saveram_mask, .saveram_base
  );

  mem_addr_pointers u_ptrs (
    .clk, .reset, .param_ready,
    .cmd_data, .param_data, .spi_byte_cnt, .mem_next,
    .addr_out, .dac_addr_out, .msu_addr_out
  );

  mcu_mem_access u_mem (
    .clk, .reset, .cmd_ready, .param_ready,
    .cmd_data, .param_data, .mcu_rq_rdy,
    .mcu_rrq, .mcu_wrq, .mcu_data_out, .mem_next
  );

  spi_readback #(.SIGNATURE(SIGNATURE)) u_readback (
    .clk, .reset, .cmd_ready, .param_ready,
    .cmd_data, .param_data, .spi_byte_cnt, .mem_next,
    .mcu_data_in, .dac_status, .msu_status,
    .spi_data_out
  );

  audio_stream_ctrl u_audio (
    .clk, .reset, .param_ready,
    .cmd_data, .param_data, .spi_byte_cnt,
    .dac_play, .dac_reset, .dac_vol, .dac_palmode, .dac_ptr,
    .msu_ptr, .msu_reset, .msu_status_set, .msu_status_clr,
    .msu_status_we
  );

endmodule

//--- sim/mcu_cmd_chk.sv
`timescale 1ns/1ps

module mcu_cmd_chk (
  input logic clk,
  input logic reset,
  input logic mcu_rrq,
  input logic mcu_wrq,
  input logic dac_reset,
  input logic msu_reset
);

  //////////////////////////////////////////////////
  // request and pulse rules
  no_rw_overlap: assert property (@(posedge clk) disable iff (reset) !(mcu_rrq && mcu_wrq))
    else $error("mcu_rrq and mcu_wrq high in the same cycle");
  rrq_one_cycle: assert property (@(posedge clk) disable iff (reset) mcu_rrq |=> !mcu_rrq)
    else $error("mcu_rrq held longer than one cycle");
  wrq_one_cycle: assert property (@(posedge clk) disable iff (reset) mcu_wrq |=> !mcu_wrq)
    else $error("mcu_wrq held longer than one cycle");
  dac_rst_pulse: assert property (@(posedge clk) disable iff (reset) dac_reset |=> !dac_reset)
    else $error("dac_reset held longer than one cycle");
  msu_rst_pulse: assert property (@(posedge clk) disable iff (reset) msu_reset |=> !msu_reset)
    else $error("msu_reset held longer than one cycle");
  idle_after_reset: assert property (@(posedge clk) reset |=> !mcu_rrq && !mcu_wrq)
    else $error("request high in the cycle after reset");

endmodule

bind mcu_cmd_top mcu_cmd_chk u_chk (.clk, .reset, .mcu_rrq, .mcu_wrq, .dac_reset, .msu_reset);

//--- sim/mcu_cmd_tb.sv
`timescale 1ns/1ps

module mcu_cmd_tb import mcu_cmd_pkg::*; ();

  logic                    clk          = 1'b0;
  logic                    reset        = 1'b1;
  logic                    cmd_ready    = 1'b0;
  logic                    param_ready  = 1'b0;
  logic [7:0]              cmd_data     = 8'h00;
  logic [7:0]              param_data   = 8'h00;
  byte_cnt_t               spi_byte_cnt = '0;
  logic                    mcu_rq_rdy   = 1'b0;
  logic [7:0]              mcu_data_in  = 8'h00;
  logic                    dac_status   = 1'b0;
  logic [7:0]              msu_status   = 8'h00;
  logic [2:0]              mapper;
  logic [ROM_ADDR_W-1:0]   rom_mask, saveram_mask, addr_out;
  logic [7:0]              saveram_base, mcu_data_out, spi_data_out;
  logic [DAC_ADDR_W-1:0]   dac_addr_out;
  logic [MSU_ADDR_W-1:0]   msu_addr_out, msu_ptr;
  logic                    mcu_rrq, mcu_wrq, dac_play, dac_reset, dac_palmode;
  logic [2:0]              dac_vol;
  logic [DAC_PTR_W-1:0]    dac_ptr;
  logic                    msu_reset, msu_status_we;
  logic [MSU_STATUS_W-1:0] msu_status_set, msu_status_clr;

  int          errors = 0;
  int          checks = 0;
  logic        timed_out = 1'b0;
  logic        pending = 1'b0;
  logic [1:0]  delay_cnt = 2'd0;
  logic [31:0] rng_state = 32'h28bd76fd;
  logic [23:0] exp_addr = '0;
  logic [7:0]  exp_rdata = '0; // last byte the read burst should return

  mcu_cmd_top #(.SIGNATURE(8'hA5), .MAPPER_DEFAULT(3'd1)) dut (.*);

  always #10 clk = ~clk;

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s ^ (s << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  //////////////////////////////////////////////////
  // memory arbiter model with 1 to 4 cycles per request
  always @(posedge clk) begin
    if (reset) begin
      mcu_rq_rdy <= 1'b0;
      pending    <= 1'b0;
    end else begin
      mcu_rq_rdy <= 1'b0;
      if (mcu_rrq || mcu_wrq) begin
        rng_state = xorshift32(rng_state);
        delay_cnt <= rng_state[1:0];
        pending   <= 1'b1;
      end else if (pending) begin
        if (delay_cnt == 2'd0) begin
          mcu_rq_rdy  <= 1'b1;
          mcu_data_in <= addr_out[7:0] + 8'h3C; // data tied to address
          pending     <= 1'b0;
        end else begin
          delay_cnt <= delay_cnt - 2'd1;
        end
      end
    end
  end

  task automatic compare(input string what, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("error at time %0t: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  // each strobe returns at the falling edge after the clock that took it
  task automatic issue_opcode(input logic [7:0] op);
    @(posedge clk);
    cmd_ready    <= 1'b1;
    cmd_data     <= op;
    spi_byte_cnt <= 8'd1;
    @(posedge clk);
    cmd_ready <= 1'b0;
    @(negedge clk);
  endtask

  task automatic push_param(input logic [7:0] b, input byte_cnt_t cnt);
    @(posedge clk);
    param_ready  <= 1'b1;
    param_data   <= b;
    spi_byte_cnt <= cnt;
    @(posedge clk);
    param_ready <= 1'b0;
    @(negedge clk);
  endtask

  // first parameter sits in the top byte
  task automatic send_cmd(input logic [7:0] op, input logic [31:0] params, input int n);
    int i;
    issue_opcode(op);
    for (i = 0; i < n; i++)
      push_param(params[31-8*i -: 8], byte_cnt_t'(i + 2));
  endtask

  task automatic wait_mem_done();
    int n;
    n = 0;
    while (!mcu_rq_rdy && n < 20) begin
      @(negedge clk);
      n++;
    end
    if (!mcu_rq_rdy) begin
      $display("timeout: memory request got no mcu_rq_rdy within 20 cycles");
      timed_out = 1'b1;
    end
    repeat (2) @(posedge clk); // mem_next then the pointer and data update
    @(negedge clk);
  endtask

  task automatic identity_test();
    logic [7:0] b;
    int i;
    compare("mapper after reset", mapper, 1);
    compare("addr_out after reset", addr_out, 0);
    compare("dac_addr_out after reset", dac_addr_out, 0);
    compare("msu_addr_out after reset", msu_addr_out, 0);
    compare("dac_ptr after reset", dac_ptr, 0);
    compare("msu_ptr after reset", msu_ptr, 0);
    compare("mcu_rrq after reset", mcu_rrq, 0);
    compare("mcu_wrq after reset", mcu_wrq, 0);
    issue_opcode(8'hF0);
    compare("signature", spi_data_out, 8'hA5);
    issue_opcode(8'hFF);
    for (i = 0; i < 3; i++) begin
      b = 8'h5A ^ (8'h33 * 8'(i));
      push_param(b, byte_cnt_t'(i + 2));
      compare("echo byte", spi_data_out, b);
    end
  endtask

  task automatic config_test();
    send_cmd(8'h35, 32'h0, 0);
    compare("mapper", mapper, 5);
    send_cmd(8'h10, 32'h12345600, 3);
    compare("rom_mask", rom_mask, 24'h123456);
    send_cmd(8'h20, 32'hABCDEF00, 3);
    compare("saveram_mask", saveram_mask, 24'hABCDEF);
    send_cmd(8'h21, 32'h5A000000, 1);
    compare("saveram_base", saveram_base, 8'h5A);
    compare("saveram_mask after base load", saveram_mask, 24'hABCDEF);
  endtask

  task automatic pointer_load_test();
    send_cmd(8'h00, 32'h12345600, 3);
    compare("addr_out", addr_out, 24'h123456);
    send_cmd(8'h01, 32'hFD420000, 2);
    compare("dac_addr_out", dac_addr_out, 11'h542); // bits 10:8 from FD
    send_cmd(8'h02, 32'hE9170000, 2);
    compare("msu_addr_out", msu_addr_out, 14'h2917);
  endtask

  task automatic read_burst_test();
    int i;
    send_cmd(8'h00, 32'h0102FE00, 3); // low byte wraps during the burst
    exp_addr = 24'h0102FE;
    issue_opcode(8'h88);
    for (i = 0; i < 4; i++) begin
      if (i > 0)
        push_param(8'hA0 + 8'(i), byte_cnt_t'(i + 1));
      compare("mcu_rrq", mcu_rrq, 1);
      exp_rdata = exp_addr[7:0] + 8'h3C;
      wait_mem_done();
      compare("read data", spi_data_out, exp_rdata);
      exp_addr = exp_addr + 24'd1;
      compare("addr_out after read", addr_out, exp_addr);
    end
  endtask

  task automatic write_burst_test();
    logic [7:0] b;
    int i;
    issue_opcode(8'h98);
    compare("mcu_wrq on opcode", mcu_wrq, 0);
    for (i = 0; i < 3; i++) begin
      b = 8'h11 * 8'(i + 1);
      push_param(b, byte_cnt_t'(i + 2));
      compare("mcu_wrq", mcu_wrq, 1);
      compare("mcu_data_out", mcu_data_out, b);
      wait_mem_done();
      exp_addr = exp_addr + 24'd1;
      compare("addr_out after write", addr_out, exp_addr);
    end
    compare("spi_data_out during write", spi_data_out, exp_rdata);
  endtask

  task automatic audio_status_test();
    issue_opcode(8'hE3);
    push_param(8'h01, 8'd2);
    compare("dac_reset before byte 3", dac_reset, 0);
    push_param(8'h34, 8'd3);
    compare("dac_reset", dac_reset, 1);
    compare("dac_ptr", dac_ptr, 9'h134);
    send_cmd(8'hE2, 32'h0, 1);
    compare("dac_play after E2", dac_play, 1);
    send_cmd(8'hE1, 32'h0, 1);
    compare("dac_play after E1", dac_play, 0);
    send_cmd(8'hEC, 32'h85000000, 1);
    compare("dac_vol", dac_vol, 5);
    compare("dac_palmode", dac_palmode, 1);
    issue_opcode(8'hE4);
    push_param(8'hEA, 8'd2);
    compare("msu_reset before byte 3", msu_reset, 0);
    push_param(8'h5C, 8'd3);
    compare("msu_reset", msu_reset, 1);
    compare("msu_ptr", msu_ptr, 14'h2A5C);
    issue_opcode(8'hE0);
    push_param(8'hD5, 8'd2);
    compare("msu_status_set", msu_status_set, 6'h15);
    compare("msu_status_we after byte 2", msu_status_we, 0);
    push_param(8'h2A, 8'd3);
    compare("msu_status_clr", msu_status_clr, 6'h2A);
    compare("msu_status_we after byte 3", msu_status_we, 1);
    push_param(8'h00, 8'd4);
    compare("msu_status_we after byte 4", msu_status_we, 0);
    @(posedge clk);
    dac_status <= 1'b1;
    msu_status <= 8'hC3;
    issue_opcode(8'hF1);
    compare("status byte, odd count", spi_data_out, 8'h60); // dac at 6, msu bit 7 at 5
    push_param(8'h00, 8'd2);
    compare("status byte, even count", spi_data_out, 8'h43);
  endtask

  initial begin
    repeat (5) @(posedge clk);
    reset <= 1'b0;
    @(negedge clk);
    identity_test();
    config_test();
    pointer_load_test();
    read_burst_test();
    write_burst_test();
    audio_status_test();
    $display("checks %0d, errors %0d, timeouts %0d", checks, errors, timed_out);
    if (errors == 0 && !timed_out)
      $display("Regression passed");
    else
      $display("Regression failed");
    $finish;
  end

endmodule

//--- sources.f
design/mcu_cmd_pkg.sv
design/cart_config_regs.sv
design/mem_addr_pointers.sv
design/mcu_mem_access.sv
design/spi_readback.sv
design/audio_stream_ctrl.sv
design/mcu_cmd_top.sv
sim/mcu_cmd_chk.sv
sim/mcu_cmd_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
set -u
cd "$(dirname "$0")"

log=sim.log

if ! verilator --binary --timing --assert -Wno-fatal -f sources.f \
    --top-module mcu_cmd_tb -o mcu_cmd_sim > build.log 2>&1; then
  cat build.log
  echo "build failed"
  exit 1
fi

if ! ./obj_dir/mcu_cmd_sim > "$log" 2>&1; then
  cat "$log"
  echo "simulation exited with an error"
  exit 1
fi
cat "$log"

if grep -q "Regression failed" "$log"; then
  exit 1
fi
exit 0
